//--- compile.f
source/mul_pkg.sv
source/mul_issue.sv
source/mul_stage.sv
source/mul_pipeline.sv
source/mul_writeback.sv
source/mul_unit.sv
testbench/mul_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the multiply unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module mul_unit_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vmul_unit_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "Test completed successfully"; then
	exit 0
fi

exit 1

//--- testbench/mul_trace.txt
# idle op rs1 rs2 rd expected
# idle and rd in decimal, op 0 MUL 1 MULH 2 MULHSU 3 MULHU, words in hex
3 0 00000000 00000000 1 00000000
0 0 00000003 00000005 2 0000000f
0 0 ffffffff ffffffff 3 00000001
0 3 ffffffff ffffffff 4 fffffffe
0 1 ffffffff ffffffff 5 00000000
0 2 ffffffff ffffffff 6 ffffffff
0 1 80000000 ffffffff 7 00000000
0 0 80000000 ffffffff 8 80000000
0 1 80000000 80000000 9 40000000
0 3 80000000 80000000 10 40000000
0 2 80000000 80000000 11 c0000000
2 1 00000000 12345678 12 00000000
0 2 7fffffff ffffffff 13 7ffffffe
0 3 7fffffff ffffffff 14 7ffffffe
0 1 7fffffff ffffffff 15 ffffffff
0 0 7fffffff ffffffff 16 80000001
0 1 00010000 00010000 17 00000001
0 0 00010000 00010000 18 00000000
0 1 fffffffe 00000003 19 ffffffff
0 0 fffffffe 00000003 20 fffffffa
0 3 fffffffe 00000003 21 00000002
0 2 fffffffe 00000003 22 ffffffff
0 2 00000003 fffffffe 23 00000002
0 1 00000003 fffffffe 24 ffffffff
5 0 12345678 00000010 25 23456780
0 3 12345678 00000010 26 00000001
0 1 80000000 7fffffff 27 c0000000
0 0 80000000 7fffffff 28 80000000
0 3 00000001 00000001 29 00000000
0 0 00000001 00000001 30 00000001
1 1 80000000 00000001 31 ffffffff
0 2 80000000 ffffffff 0 80000000
0 3 80000000 ffffffff 1 7fffffff
0 0 0000ffff 0000ffff 2 fffe0001
0 3 0000ffff 0000ffff 3 00000000
4 0 deadbeef 00000000 4 00000000
0 1 ffff0000 ffff0000 5 00000001
0 3 ffff0000 ffff0000 6 fffe0001

//--- testbench/mul_unit_tb.sv
module mul_unit_tb import mul_pkg::*; ();

	localparam int XLEN      = 32;
	localparam int NUM_STAGE = 4;

	logic                     clock;
	logic                     reset;
	logic                     req_valid;
	mul_op_t                  req_op;
	logic [XLEN-1:0]          req_rs1;
	logic [XLEN-1:0]          req_rs2;
	logic [REG_TAG_WIDTH-1:0] req_rd;
	logic                     resp_valid;
	logic [REG_TAG_WIDTH-1:0] resp_rd;
	logic [XLEN-1:0]          resp_result;

	// Trace contents
	int                       idle_q[$];
	mul_op_t                  op_q[$];
	logic [XLEN-1:0]          rs1_q[$];
	logic [XLEN-1:0]          rs2_q[$];
	logic [REG_TAG_WIDTH-1:0] rd_q[$];
	logic [XLEN-1:0]          result_q[$];

	// Outstanding requests, oldest first
	logic [REG_TAG_WIDTH-1:0] pend_rd_q[$];
	logic [XLEN-1:0]          pend_result_q[$];
	int                       pend_cycle_q[$];

	int cycle;
	int value_errors;
	int latency_errors;
	int protocol_errors;
	bit trace_loaded;

	mul_unit #(
		.XLEN      (XLEN),
		.NUM_STAGE (NUM_STAGE)
	) u_mul_unit (
		.clock       (clock),
		.reset       (reset),
		.req_valid   (req_valid),
		.req_op      (req_op),
		.req_rs1     (req_rs1),
		.req_rs2     (req_rs2),
		.req_rd      (req_rd),
		.resp_valid  (resp_valid),
		.resp_rd     (resp_rd),
		.resp_result (resp_result)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	task automatic read_trace(output bit ok);
		int    fd;
		int    fields;
		int    idle_val;
		int    op_val;
		int    rd_val;
		string line;
		logic [XLEN-1:0] rs1_val;
		logic [XLEN-1:0] rs2_val;
		logic [XLEN-1:0] exp_val;
		ok = 1'b0;
		fd = $fopen("testbench/mul_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open the trace file testbench/mul_trace.txt");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			// Skip comments and blank lines
			if (line.len() < 2 || line[0] == "#") begin
				continue;
			end
			fields = $sscanf(line, "%d %d %h %h %d %h",
				idle_val, op_val, rs1_val, rs2_val, rd_val, exp_val);
			if (fields != 6 || op_val < 0 || op_val > 3) begin
				$display("unreadable trace line: %s", line);
				protocol_errors++;
				continue;
			end
			idle_q.push_back(idle_val);
			op_q.push_back(mul_op_t'(op_val[1:0]));
			rs1_q.push_back(rs1_val);
			rs2_q.push_back(rs2_val);
			rd_q.push_back(rd_val[REG_TAG_WIDTH-1:0]);
			result_q.push_back(exp_val);
		end
		$fclose(fd);
		ok = (idle_q.size() != 0);
		if (!ok) begin
			$display("the trace file holds no requests");
		end
	endtask

	// Drives the trace, then waits for the pipeline to drain
	initial begin : drive_requests
		bit ok;
		int waited;
		clock = 1'b0;
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = MUL_LO;
		req_rs1 = '0;
		req_rs2 = '0;
		req_rd = '0;
		cycle = 0;
		value_errors = 0;
		latency_errors = 0;
		protocol_errors = 0;
		trace_loaded = 1'b0;
		read_trace(ok);
		if (!ok) begin
			$display("Test failed");
			$finish;
		end else begin
			trace_loaded = 1'b1;
			repeat (2) @(posedge clock);
			reset <= 1'b0;
			for (int i = 0; i < idle_q.size(); i++) begin
				repeat (idle_q[i]) begin
					@(posedge clock);
					req_valid <= 1'b0;
				end
				@(posedge clock);
				req_valid <= 1'b1;
				req_op <= op_q[i];
				req_rs1 <= rs1_q[i];
				req_rs2 <= rs2_q[i];
				req_rd <= rd_q[i];
				// DUT samples the request on the next edge
				pend_rd_q.push_back(rd_q[i]);
				pend_result_q.push_back(result_q[i]);
				pend_cycle_q.push_back(cycle + 1);
			end
			@(posedge clock);
			req_valid <= 1'b0;
			waited = 0;
			while (pend_rd_q.size() != 0 && waited < NUM_STAGE + 6) begin
				@(posedge clock);
				waited++;
			end
			repeat (2) @(posedge clock);
			if (pend_rd_q.size() != 0) begin
				$display("%0d responses never arrived", pend_rd_q.size());
				protocol_errors += pend_rd_q.size();
			end
			$display("errors: value %0d, latency %0d, protocol %0d",
				value_errors, latency_errors, protocol_errors);
			if (value_errors + latency_errors + protocol_errors == 0) begin
				$display("Test completed successfully");
			end else begin
				$display("Test failed");
			end
			$finish;
		end
	end

	// Outputs are settled by the falling edge
	always @(negedge clock) begin : check_response
		logic [REG_TAG_WIDTH-1:0] exp_rd;
		logic [XLEN-1:0]          exp_result;
		int                       exp_cycle;
		if (!reset && trace_loaded) begin
			if (resp_valid === 1'b1) begin
				if (pend_rd_q.size() == 0) begin
					$display("response at %0t with no outstanding request", $time);
					protocol_errors++;
				end else begin
					exp_rd = pend_rd_q.pop_front();
					exp_result = pend_result_q.pop_front();
					exp_cycle = pend_cycle_q.pop_front() + NUM_STAGE + 2;
					if (resp_rd !== exp_rd) begin
						$display("mismatch at %0t: resp_rd expected %0d actual %0d",
							$time, exp_rd, resp_rd);
						value_errors++;
					end
					if (resp_result !== exp_result) begin
						$display("mismatch at %0t: resp_result expected %08h actual %08h",
							$time, exp_result, resp_result);
						value_errors++;
					end
					if (cycle != exp_cycle) begin
						$display("response for rd %0d came in cycle %0d instead of cycle %0d",
							exp_rd, cycle, exp_cycle);
						latency_errors++;
					end
				end
			end else if (resp_valid !== 1'b0) begin
				$display("resp_valid is unknown at %0t", $time);
				protocol_errors++;
			end
		end
	end

	initial begin : watchdog
		int limit;
		int total_idle;
		wait (trace_loaded);
		total_idle = 0;
		foreach (idle_q[i]) begin
			total_idle += idle_q[i];
		end
		limit = (idle_q.size() + total_idle + NUM_STAGE + 20) * 40;
		#(limit);
		$display("ran out of time at %0t with %0d responses outstanding",
			$time, pend_rd_q.size());
		$display("Test failed");
		$finish;
	end

endmodule

//--- source/mul_unit.sv
module mul_unit import mul_pkg::*; #(
	parameter int XLEN      = 32,
	parameter int NUM_STAGE = 4
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     req_valid,
	input  mul_op_t                  req_op,
	input  logic [XLEN-1:0]          req_rs1,
	input  logic [XLEN-1:0]          req_rs2,
	input  logic [REG_TAG_WIDTH-1:0] req_rd,
	output logic                     resp_valid,
	output logic [REG_TAG_WIDTH-1:0] resp_rd,
	output logic [XLEN-1:0]          resp_result
);

	logic                     issue_start;
	logic [2*XLEN-1:0]        issue_mcand;
	logic [2*XLEN-1:0]        issue_mplier;
	mul_op_t                  issue_op;
	logic [REG_TAG_WIDTH-1:0] issue_rd;

	logic                     pipe_done;
	logic [2*XLEN-1:0]        pipe_product;
	mul_op_t                  pipe_op;
	logic [REG_TAG_WIDTH-1:0] pipe_rd;

	mul_issue #(
		.XLEN (XLEN)
	) u_issue (
		.clock     (clock),
		.reset     (reset),
		.req_valid (req_valid),
		.req_op    (req_op),
		.req_rs1   (req_rs1),
		.req_rs2   (req_rs2),
		.req_rd    (req_rd),
		.start     (issue_start),
		.mcand     (issue_mcand),
		.mplier    (issue_mplier),
		.op        (issue_op),
		.rd        (issue_rd)
	);

	mul_pipeline #(
		.XLEN      (XLEN),
		.NUM_STAGE (NUM_STAGE)
	) u_pipeline (
		.clock   (clock),
		.reset   (reset),
		.start   (issue_start),
		.mcand   (issue_mcand),
		.mplier  (issue_mplier),
		.op      (issue_op),
		.rd      (issue_rd),
		.done    (pipe_done),
		.product (pipe_product),
		.out_op  (pipe_op),
		.out_rd  (pipe_rd)
	);

	mul_writeback #(
		.XLEN (XLEN)
	) u_writeback (
		.clock       (clock),
		.reset       (reset),
		.done        (pipe_done),
		.product     (pipe_product),
		.op          (pipe_op),
		.rd          (pipe_rd),
		.resp_valid  (resp_valid),
		.resp_rd     (resp_rd),
		.resp_result (resp_result)
	);

endmodule

//--- source/mul_writeback.sv
module mul_writeback import mul_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     done,
	input  logic [2*XLEN-1:0]        product,
	input  mul_op_t                  op,
	input  logic [REG_TAG_WIDTH-1:0] rd,
	output logic                     resp_valid,
	output logic [REG_TAG_WIDTH-1:0] resp_rd,
	output logic [XLEN-1:0]          resp_result
);

	logic [XLEN-1:0] result_sel;

	// Low word for MUL, high word for the MULH variants
	always_comb begin
		if (op == MUL_LO) begin
			result_sel = product[XLEN-1:0];
		end else begin
			result_sel = product[2*XLEN-1:XLEN];
		end
	end

	always_ff @(posedge clock) begin
		resp_result <= result_sel;
		resp_rd     <= rd;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= done;
		end
	end

endmodule

//--- source/mul_pipeline.sv
module mul_pipeline import mul_pkg::*; #(
	parameter int XLEN      = 32,
	parameter int NUM_STAGE = 4
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     start,
	input  logic [2*XLEN-1:0]        mcand,
	input  logic [2*XLEN-1:0]        mplier,
	input  mul_op_t                  op,
	input  logic [REG_TAG_WIDTH-1:0] rd,
	output logic                     done,
	output logic [2*XLEN-1:0]        product,
	output mul_op_t                  out_op,
	output logic [REG_TAG_WIDTH-1:0] out_rd
);

	localparam int DW = 2 * XLEN;

	// Slice 0 feeds the first stage, slice i+1 is driven by stage i
	logic [NUM_STAGE:0]          done_chain;
	logic [(NUM_STAGE+1)*DW-1:0] product_chain;
	logic [(NUM_STAGE+1)*DW-1:0] mcand_chain;
	logic [(NUM_STAGE+1)*DW-1:0] mplier_chain;

	mul_op_t                  op_pipe [NUM_STAGE];
	logic [REG_TAG_WIDTH-1:0] rd_pipe [NUM_STAGE];

	assign done_chain[0]          = start;
	assign product_chain[DW-1:0]  = '0;
	assign mcand_chain[DW-1:0]    = mcand;
	assign mplier_chain[DW-1:0]   = mplier;

	mul_stage #(
		.XLEN      (XLEN),
		.NUM_STAGE (NUM_STAGE)
	) u_stage [NUM_STAGE-1:0] (
		.clock       (clock),
		.reset       (reset),
		.start       (done_chain[NUM_STAGE-1:0]),
		.product_in  (product_chain[NUM_STAGE*DW-1:0]),
		.mcand_in    (mcand_chain[NUM_STAGE*DW-1:0]),
		.mplier_in   (mplier_chain[NUM_STAGE*DW-1:0]),
		.done        (done_chain[NUM_STAGE:1]),
		.product_out (product_chain[(NUM_STAGE+1)*DW-1:DW]),
		.mcand_out   (mcand_chain[(NUM_STAGE+1)*DW-1:DW]),
		.mplier_out  (mplier_chain[(NUM_STAGE+1)*DW-1:DW])
	);

	// Op and tag ride alongside, one register per stage
	always_ff @(posedge clock) begin
		op_pipe[0] <= op;
		rd_pipe[0] <= rd;
		for (int i = 1; i < NUM_STAGE; i++) begin
			op_pipe[i] <= op_pipe[i-1];
			rd_pipe[i] <= rd_pipe[i-1];
		end
	end

	assign done    = done_chain[NUM_STAGE];
	assign product = product_chain[(NUM_STAGE+1)*DW-1:NUM_STAGE*DW];
	assign out_op  = op_pipe[NUM_STAGE-1];
	assign out_rd  = rd_pipe[NUM_STAGE-1];

endmodule

//--- source/mul_stage.sv
module mul_stage #(
	parameter int XLEN      = 32,
	parameter int NUM_STAGE = 4
) (
	input  logic              clock,
	input  logic              reset,
	input  logic              start,
	input  logic [2*XLEN-1:0] product_in,
	input  logic [2*XLEN-1:0] mcand_in,
	input  logic [2*XLEN-1:0] mplier_in,
	output logic              done,
	output logic [2*XLEN-1:0] product_out,
	output logic [2*XLEN-1:0] mcand_out,
	output logic [2*XLEN-1:0] mplier_out
);

	// Multiplier bits consumed per stage
	localparam int SLICE = (2 * XLEN) / NUM_STAGE;

	logic [2*XLEN-1:0] product_reg;
	logic [2*XLEN-1:0] partial_reg;
	logic [2*XLEN-1:0] partial_next;
	logic [2*XLEN-1:0] mcand_next;
	logic [2*XLEN-1:0] mplier_next;

	assign partial_next = mplier_in[SLICE-1:0] * mcand_in;

	// Next stage sees the following slice, weighted by the shifted multiplicand
	assign mplier_next = mplier_in >> SLICE;
	assign mcand_next  = mcand_in << SLICE;

	always_ff @(posedge clock) begin
		product_reg <= product_in;
		partial_reg <= partial_next;
		mplier_out  <= mplier_next;
		mcand_out   <= mcand_next;
	end

	// Accumulate after the register to keep the adder off the multiply path
	assign product_out = product_reg + partial_reg;

	always_ff @(posedge clock) begin
		if (reset) begin
			done <= 1'b0;
		end else begin
			done <= start;
		end
	end

endmodule

//--- source/mul_issue.sv
module mul_issue import mul_pkg::*; #(
	parameter int XLEN = 32
) (
	input  logic                     clock,
	input  logic                     reset,
	input  logic                     req_valid,
	input  mul_op_t                  req_op,
	input  logic [XLEN-1:0]          req_rs1,
	input  logic [XLEN-1:0]          req_rs2,
	input  logic [REG_TAG_WIDTH-1:0] req_rd,
	output logic                     start,
	output logic [2*XLEN-1:0]        mcand,
	output logic [2*XLEN-1:0]        mplier,
	output mul_op_t                  op,
	output logic [REG_TAG_WIDTH-1:0] rd
);

	logic              rs1_signed;
	logic              rs2_signed;
	logic [2*XLEN-1:0] mcand_ext;
	logic [2*XLEN-1:0] mplier_ext;

	// rs1 is signed for MULH and MULHSU, rs2 only for MULH
	assign rs1_signed = (req_op == MUL_HI_SS) || (req_op == MUL_HI_SU);
	assign rs2_signed = (req_op == MUL_HI_SS);

	always_comb begin
		if (rs1_signed) begin
			mcand_ext = {{XLEN{req_rs1[XLEN-1]}}, req_rs1};
		end else begin
			mcand_ext = {{XLEN{1'b0}}, req_rs1};
		end
		if (rs2_signed) begin
			mplier_ext = {{XLEN{req_rs2[XLEN-1]}}, req_rs2};
		end else begin
			mplier_ext = {{XLEN{1'b0}}, req_rs2};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			start <= 1'b0;
		end else begin
			start <= req_valid;
		end
	end

	// Operands and tag
	always_ff @(posedge clock) begin
		mcand  <= mcand_ext;
		mplier <= mplier_ext;
		op     <= req_op;
		rd     <= req_rd;
	end

endmodule

//--- source/mul_pkg.sv
package mul_pkg;

	// Multiply operations, encoded as funct3
	typedef enum logic [1:0] {
		MUL_LO    = 2'd0,
		MUL_HI_SS = 2'd1,
		MUL_HI_SU = 2'd2,
		MUL_HI_UU = 2'd3
	} mul_op_t;

	// Destination register index
	localparam int REG_TAG_WIDTH = 5;

endpackage
